// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cpu address layout, low to high
    //   [OFFSET_W-1:0]       byte within line
    //   [OFFSET_W-1 -: 3]    word within line
    //   [OFFSET_W +: INDEX]  set index, width set per module
    //   rest                 tag
    localparam int ADDR_W         = 32;
    localparam int OFFSET_W       = 5;
    localparam int WORD_SEL_W     = 3;
    localparam int WORDS_PER_LINE = 8;

    typedef logic [31:0] word_t;

    // word 0 in the low bits
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    typedef logic [3:0] strb_t;   // one bit per byte lane

    typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// File: hw/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array #(
    parameter int  INDEX_W   = 7,
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               we_i,
    input  logic [INDEX_W-1:0] waddr_i,
    input  payload_t           wdata_i,
    input  logic [INDEX_W-1:0] raddr_i,
    output payload_t           rdata_o
);

    localparam int DEPTH = 1 << INDEX_W;

    payload_t mem_q [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // write-first on a same-index collision
    always_ff @(posedge clk) begin
        if (we_i && (waddr_i == raddr_i)) begin
            rdata_o <= wdata_i;
        end else begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_stage #(
    parameter int INDEX_W = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               hold_i,
    input  logic               valid_i,
    input  logic               we_i,
    input  dcache_pkg::addr_t  addr_i,
    input  dcache_pkg::strb_t  wstrb_i,
    input  dcache_pkg::word_t  wdata_i,
    output logic               s2_valid_o,
    output logic               s2_we_o,
    output dcache_pkg::addr_t  s2_addr_o,
    output dcache_pkg::strb_t  s2_wstrb_o,
    output dcache_pkg::word_t  s2_wdata_o,
    output logic [INDEX_W-1:0] rd_index_o
);

    import dcache_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst) begin
            s2_valid_o <= 1'b0;
            s2_we_o    <= 1'b0;
        end else if (!hold_i) begin
            s2_valid_o <= valid_i;
            s2_we_o    <= we_i;
        end
    end

    // request fields
    always_ff @(posedge clk) begin
        if (!hold_i) begin
            s2_addr_o  <= addr_i;
            s2_wstrb_o <= wstrb_i;
            s2_wdata_o <= wdata_i;
        end
    end

    // stalled request keeps its own set on the array read port
    assign rd_index_o = hold_i ? s2_addr_o[OFFSET_W +: INDEX_W]
                               : addr_i[OFFSET_W +: INDEX_W];

endmodule

`default_nettype wire

// File: hw/dcache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup #(
    parameter int INDEX_W = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               s2_valid_i,
    input  logic               s2_we_i,
    input  dcache_pkg::addr_t  s2_addr_i,
    input  dcache_pkg::strb_t  s2_wstrb_i,
    input  dcache_pkg::word_t  s2_wdata_i,
    input  logic [INDEX_W-1:0] rd_index_i,
    input  logic               ret_valid_i,
    input  dcache_pkg::line_t  ret_data_i,
    input  logic               wb_busy_i,
    output logic               stall_o,
    output logic               data_ok_o,
    output dcache_pkg::word_t  rdata_o,
    output logic               fill_pending_o,
    output dcache_pkg::addr_t  fill_addr_o,
    output logic               victim_load_o,
    output dcache_pkg::addr_t  victim_addr_o,
    output dcache_pkg::line_t  victim_line_o
);

    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0]      s2_tag;
    logic [INDEX_W-1:0]    s2_index;
    logic [WORD_SEL_W-1:0] s2_word;

    logic [TAG_W-1:0] tag_rd [2];
    line_t            line_rd [2];
    logic [1:0]       hit_way;
    logic [1:0]       way_we;

    logic hit;
    logic miss;
    logic fill;
    logic victim;

    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    logic [SETS-1:0]      lru_q;   // way to replace next

    line_t base_line;
    line_t wr_line;
    word_t base_word;
    word_t strb_mask;

    assign s2_tag   = s2_addr_i[ADDR_W-1 -: TAG_W];
    assign s2_index = s2_addr_i[OFFSET_W +: INDEX_W];
    assign s2_word  = s2_addr_i[OFFSET_W-1 -: WORD_SEL_W];

    assign victim = lru_q[s2_index];

    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_array #(
            .INDEX_W   (INDEX_W),
            .payload_t (logic [TAG_W-1:0])
        ) u_tag (
            .clk     (clk),
            .we_i    (way_we[w]),
            .waddr_i (s2_index),
            .wdata_i (s2_tag),
            .raddr_i (rd_index_i),
            .rdata_o (tag_rd[w])
        );

        dcache_array #(
            .INDEX_W   (INDEX_W),
            .payload_t (line_t)
        ) u_line (
            .clk     (clk),
            .we_i    (way_we[w]),
            .waddr_i (s2_index),
            .wdata_i (wr_line),
            .raddr_i (rd_index_i),
            .rdata_o (line_rd[w])
        );

        assign hit_way[w] = valid_q[w][s2_index] && (tag_rd[w] == s2_tag);
        assign way_we[w]  = (fill && (victim == 1'(w))) || (hit && s2_we_i && hit_way[w]);
    end

    assign hit  = s2_valid_i && (|hit_way);
    assign miss = s2_valid_i && !(|hit_way);
    assign fill = miss && ret_valid_i && !wb_busy_i;

    // hit line or returned line, then strobed merge
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            strb_mask[8*b +: 8] = {8{s2_wstrb_i[b]}};
        end
        base_line = hit ? (hit_way[1] ? line_rd[1] : line_rd[0]) : ret_data_i;
        base_word = base_line[32*s2_word +: 32];
        wr_line   = base_line;
        if (s2_we_i) begin
            wr_line[32*s2_word +: 32] = (s2_wdata_i & strb_mask) | (base_word & ~strb_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (fill) begin
            valid_q[victim][s2_index] <= 1'b1;
            dirty_q[victim][s2_index] <= s2_we_i;   // write miss lands dirty
            lru_q[s2_index]           <= !victim;
        end else if (hit) begin
            if (s2_we_i) begin
                dirty_q[hit_way[1]][s2_index] <= 1'b1;
            end
            lru_q[s2_index] <= hit_way[0];   // the other way ages
        end
    end

    assign stall_o   = miss && !fill;
    assign data_ok_o = s2_valid_i && !s2_we_i && (hit || fill);
    assign rdata_o   = base_word;

    assign fill_pending_o = miss && !ret_valid_i;
    assign fill_addr_o    = {s2_tag, s2_index, {OFFSET_W{1'b0}}};

    // dirty victim leaves in the refill cycle
    assign victim_load_o = fill && valid_q[victim][s2_index] && dirty_q[victim][s2_index];
    assign victim_addr_o = {tag_rd[victim], s2_index, {OFFSET_W{1'b0}}};
    assign victim_line_o = line_rd[victim];

endmodule

`default_nettype wire

// File: hw/dcache_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              fill_pending_i,
    input  dcache_pkg::addr_t fill_addr_i,
    input  logic              victim_load_i,
    input  dcache_pkg::addr_t victim_addr_i,
    input  dcache_pkg::line_t victim_line_i,
    input  logic              wr_valid_i,
    output logic              rd_req_o,
    output dcache_pkg::addr_t rd_addr_o,
    output logic              wr_req_o,
    output dcache_pkg::addr_t wr_addr_o,
    output dcache_pkg::line_t wr_data_o,
    output logic              wb_busy_o
);

    logic wb_full_q;

    // one entry write-back buffer
    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_full_q <= 1'b0;
        end else if (victim_load_i) begin
            wb_full_q <= 1'b1;
        end else if (wr_valid_i) begin
            wb_full_q <= 1'b0;   // empty from next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (victim_load_i) begin
            wr_addr_o <= victim_addr_i;
            wr_data_o <= victim_line_i;
        end
    end

    assign wr_req_o  = wb_full_q;
    assign wb_busy_o = wb_full_q;

    // refill waits behind a pending write-back to the same memory
    assign rd_req_o  = fill_pending_i && !wb_full_q;
    assign rd_addr_o = fill_addr_i;

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int INDEX_W = 7
) (
    input  logic              clk,
    input  logic              rst,
    // cpu side
    input  logic              valid_i,
    input  logic              we_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::strb_t wstrb_i,
    input  dcache_pkg::word_t wdata_i,
    output logic              stall_o,
    output logic              data_ok_o,
    output dcache_pkg::word_t rdata_o,
    // refill
    output logic              rd_req_o,
    output dcache_pkg::addr_t rd_addr_o,
    input  logic              ret_valid_i,
    input  dcache_pkg::line_t ret_data_i,
    // write-back
    output logic              wr_req_o,
    output dcache_pkg::addr_t wr_addr_o,
    output dcache_pkg::line_t wr_data_o,
    input  logic              wr_valid_i
);

    import dcache_pkg::*;

    logic               s2_valid;
    logic               s2_we;
    addr_t              s2_addr;
    strb_t              s2_wstrb;
    word_t              s2_wdata;
    logic [INDEX_W-1:0] rd_index;

    logic  fill_pending;
    addr_t fill_addr;
    logic  victim_load;
    addr_t victim_addr;
    line_t victim_line;
    logic  wb_busy;

    dcache_req_stage #(
        .INDEX_W (INDEX_W)
    ) u_req_stage (
        .clk        (clk),
        .rst        (rst),
        .hold_i     (stall_o),
        .valid_i    (valid_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wstrb_i    (wstrb_i),
        .wdata_i    (wdata_i),
        .s2_valid_o (s2_valid),
        .s2_we_o    (s2_we),
        .s2_addr_o  (s2_addr),
        .s2_wstrb_o (s2_wstrb),
        .s2_wdata_o (s2_wdata),
        .rd_index_o (rd_index)
    );

    dcache_lookup #(
        .INDEX_W (INDEX_W)
    ) u_lookup (
        .clk            (clk),
        .rst            (rst),
        .s2_valid_i     (s2_valid),
        .s2_we_i        (s2_we),
        .s2_addr_i      (s2_addr),
        .s2_wstrb_i     (s2_wstrb),
        .s2_wdata_i     (s2_wdata),
        .rd_index_i     (rd_index),
        .ret_valid_i    (ret_valid_i),
        .ret_data_i     (ret_data_i),
        .wb_busy_i      (wb_busy),
        .stall_o        (stall_o),
        .data_ok_o      (data_ok_o),
        .rdata_o        (rdata_o),
        .fill_pending_o (fill_pending),
        .fill_addr_o    (fill_addr),
        .victim_load_o  (victim_load),
        .victim_addr_o  (victim_addr),
        .victim_line_o  (victim_line)
    );

    dcache_mem_port u_mem_port (
        .clk            (clk),
        .rst            (rst),
        .fill_pending_i (fill_pending),
        .fill_addr_i    (fill_addr),
        .victim_load_i  (victim_load),
        .victim_addr_i  (victim_addr),
        .victim_line_i  (victim_line),
        .wr_valid_i     (wr_valid_i),
        .rd_req_o       (rd_req_o),
        .rd_addr_o      (rd_addr_o),
        .wr_req_o       (wr_req_o),
        .wr_addr_o      (wr_addr_o),
        .wr_data_o      (wr_data_o),
        .wb_busy_o      (wb_busy)
    );

endmodule

`default_nettype wire

// File: dv/dcache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_assert (
    input logic              clk,
    input logic              rst,
    input logic              stall_i,
    input logic              rd_req_i,
    input logic              wr_req_i,
    input dcache_pkg::addr_t wr_addr_i,
    input logic              wr_valid_i
);

    // quiet outputs once reset has been seen
    reset_quiet: assert property (@(posedge clk) !rst |=> (!stall_i && !wr_req_i))
        else $error("stall or write request high right after reset");

    wr_hold: assert property (@(posedge clk) disable iff (!rst)
        (wr_req_i && !wr_valid_i) |=> (wr_req_i && $stable(wr_addr_i)))
        else $error("write request dropped or address moved before acknowledge");

    one_request: assert property (@(posedge clk) disable iff (!rst) !(rd_req_i && wr_req_i))
        else $error("refill and write-back requested together");

endmodule

bind dcache_top dcache_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall_o),
    .rd_req_i   (rd_req_o),
    .wr_req_i   (wr_req_o),
    .wr_addr_i  (wr_addr_o),
    .wr_valid_i (wr_valid_i)
);

`default_nettype wire

// File: dv/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    import dcache_pkg::*;

    localparam int INDEX_W = 7;
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SEED    = 32'h30fd;
    // about 30 requests, worst case a refill queued behind a write-back
    localparam int REQUESTS       = 32;
    localparam int CYCLES_PER_REQ = 16;
    localparam int MAX_CYCLES     = REQUESTS * CYCLES_PER_REQ + 20;

    logic  clk = 1'b0;
    logic  rst;
    logic  valid_i, we_i;
    addr_t addr_i;
    strb_t wstrb_i;
    word_t wdata_i;
    logic  stall_o, data_ok_o;
    word_t rdata_o;
    logic  rd_req_o, ret_valid_i, wr_req_o, wr_valid_i;
    addr_t rd_addr_o, wr_addr_o;
    line_t ret_data_i, wr_data_o;

    int    cycle_count = 0;
    int    checks = 0;
    int    errors = 0;
    int    refill_count = 0;
    int    wb_count = 0;
    addr_t last_rd_addr;
    addr_t last_wb_addr;
    line_t last_wb_line;
    word_t mem_model [addr_t];   // backing store, word keys
    word_t sb [addr_t];          // expected cpu view

    dcache_top #(.INDEX_W(INDEX_W)) dut_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, DUT stopped answering", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic word_t default_word(input addr_t a);
        return {a[31:2], 2'b00} ^ 32'ha5a5_0000;
    endfunction

    function automatic word_t model_word(input addr_t a);
        return mem_model.exists(a) ? mem_model[a] : default_word(a);
    endfunction

    function automatic word_t expect_word(input addr_t a);
        return sb.exists(a) ? sb[a] : default_word(a);
    endfunction

    function automatic word_t merge_word(input word_t old, input word_t data, input strb_t strb);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = data[8*b +: 8];
        end
        return r;
    endfunction

    function automatic addr_t make_addr(input logic [TAG_W-1:0] tag,
                                        input logic [INDEX_W-1:0] set, input int word);
        return {tag, set, word[2:0], 2'b00};
    endfunction

    function automatic logic [TAG_W-1:0] next_tag(input logic [TAG_W-1:0] prev);
        logic [31:0] r;
        r = $urandom;
        return prev + TAG_W'(r[8:0]) + TAG_W'(1);   // never equal to prev
    endfunction

    // refill answers three cycles after the request shows
    initial begin : refill_model
        addr_t line_addr;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        forever begin
            @(negedge clk);
            if (rst && rd_req_o) begin
                line_addr    = rd_addr_o;
                last_rd_addr = rd_addr_o;
                refill_count++;
                repeat (3) @(posedge clk);
                #1;
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    ret_data_i[32*i +: 32] = model_word(line_addr + 32'(4 * i));
                end
                ret_valid_i = 1'b1;
                @(posedge clk);
                #1 ret_valid_i = 1'b0;
            end
        end
    end

    initial begin : writeback_model
        wr_valid_i = 1'b0;
        forever begin
            @(negedge clk);
            if (rst && wr_req_o) begin
                repeat (2) @(posedge clk);
                #1 wr_valid_i = 1'b1;
                last_wb_addr = wr_addr_o;
                last_wb_line = wr_data_o;
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    mem_model[wr_addr_o + 32'(4 * i)] = wr_data_o[32*i +: 32];
                end
                wb_count++;
                @(posedge clk);
                #1 wr_valid_i = 1'b0;
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // one request, lat counts cycles from acceptance to stall low
    task automatic access(input logic we, input addr_t a, input strb_t strb, input word_t data,
                          output word_t rd, output int lat);
        @(posedge clk);
        #1;
        valid_i = 1'b1;
        we_i    = we;
        addr_i  = a;
        wstrb_i = strb;
        wdata_i = data;
        @(negedge clk);
        while (stall_o) @(negedge clk);
        @(posedge clk);   // accepted here
        #1 valid_i = 1'b0;
        lat = 1;
        @(negedge clk);
        while (stall_o) begin
            @(negedge clk);
            lat++;
        end
        rd = rdata_o;
        compare("data_ok_o", 32'(data_ok_o), 32'(!we));
    endtask

    task automatic read_check(input addr_t a, output int lat);
        word_t got;
        access(1'b0, a, 4'b0000, 32'h0, got, lat);
        compare("rdata_o", got, expect_word(a));
    endtask

    task automatic write_word(input addr_t a, input strb_t strb, input word_t data);
        word_t rd;
        int    lat;
        access(1'b1, a, strb, data, rd, lat);
        sb[a] = merge_word(expect_word(a), data, strb);
    endtask

    task automatic report_test(input string name, input int e0);
        if (errors == e0) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - e0);
    endtask

    task automatic test_miss_then_hit(input logic [TAG_W-1:0] tag);
        int e0, r0, lat;
        e0 = errors;
        r0 = refill_count;
        read_check(make_addr(tag, 7'd3, 2), lat);
        compare("refill_count", refill_count - r0, 1);
        compare("rd_addr_o", last_rd_addr, make_addr(tag, 7'd3, 0));
        r0 = refill_count;
        read_check(make_addr(tag, 7'd3, 5), lat);
        compare("refill_count", refill_count - r0, 0);
        compare("hit_latency", lat, 1);
        report_test("miss_then_hit", e0);
    endtask

    task automatic test_strobes(input logic [TAG_W-1:0] tag_a);
        int e0, lat;
        logic [TAG_W-1:0] tag_b;
        e0 = errors;
        tag_b = next_tag(tag_a);
        write_word(make_addr(tag_a, 7'd17, 1), 4'b0101, $urandom);   // write miss
        read_check(make_addr(tag_a, 7'd17, 1), lat);
        write_word(make_addr(tag_a, 7'd17, 1), 4'b1000, $urandom);
        write_word(make_addr(tag_a, 7'd17, 6), 4'b0011, $urandom);
        read_check(make_addr(tag_a, 7'd17, 1), lat);
        read_check(make_addr(tag_a, 7'd17, 6), lat);
        write_word(make_addr(tag_b, 7'd17, 5), 4'b0110, $urandom);
        read_check(make_addr(tag_b, 7'd17, 5), lat);
        report_test("byte_strobes", e0);
    endtask

    task automatic test_lru(input logic [TAG_W-1:0] tag_a);
        int e0, r0, lat;
        logic [TAG_W-1:0] tag_b, tag_c;
        e0 = errors;
        tag_b = next_tag(tag_a);
        tag_c = next_tag(tag_b);
        read_check(make_addr(tag_a, 7'd42, 0), lat);
        read_check(make_addr(tag_b, 7'd42, 1), lat);
        read_check(make_addr(tag_a, 7'd42, 2), lat);   // b is now oldest
        read_check(make_addr(tag_c, 7'd42, 3), lat);
        r0 = refill_count;
        read_check(make_addr(tag_a, 7'd42, 4), lat);
        compare("refill_count", refill_count - r0, 0);
        r0 = refill_count;
        read_check(make_addr(tag_b, 7'd42, 5), lat);
        compare("refill_count", refill_count - r0, 1);
        report_test("lru_replace", e0);
    endtask

    task automatic test_write_back(input logic [TAG_W-1:0] tag_a);
        int e0, r0, w0, lat;
        logic [TAG_W-1:0] tag_b, tag_c;
        addr_t line_a;
        e0 = errors;
        tag_b = next_tag(tag_a);
        tag_c = next_tag(tag_b);
        line_a = make_addr(tag_a, 7'd77, 0);
        write_word(make_addr(tag_a, 7'd77, 2), 4'b1111, $urandom);
        write_word(make_addr(tag_a, 7'd77, 6), 4'b1100, $urandom);
        read_check(make_addr(tag_b, 7'd77, 0), lat);
        read_check(make_addr(tag_b, 7'd77, 3), lat);
        w0 = wb_count;
        read_check(make_addr(tag_c, 7'd77, 1), lat);   // evicts dirty a
        while (wb_count == w0) @(negedge clk);
        compare("wr_addr_o", last_wb_addr, line_a);
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            compare("wr_data_o", last_wb_line[32*i +: 32], expect_word(line_a + 32'(4 * i)));
        end
        r0 = refill_count;
        read_check(make_addr(tag_a, 7'd77, 2), lat);
        compare("rd_addr_o", last_rd_addr, line_a);
        read_check(make_addr(tag_a, 7'd77, 6), lat);
        compare("refill_count", refill_count - r0, 1);
        report_test("dirty_write_back", e0);
    endtask

    task automatic test_back_to_back(input logic [TAG_W-1:0] tag);
        int e0;
        addr_t base;
        e0 = errors;
        base = make_addr(tag, 7'd100, 0);
        write_word(make_addr(tag, 7'd100, 3), 4'b1111, $urandom);
        for (int i = 0; i <= WORDS_PER_LINE; i++) begin
            @(posedge clk);
            #1;
            valid_i = (i < WORDS_PER_LINE);
            we_i    = 1'b0;
            addr_i  = base + 32'(4 * i);
            @(negedge clk);
            compare("stall_o", 32'(stall_o), 0);
            if (i > 0) begin
                compare("data_ok_o", 32'(data_ok_o), 1);
                compare("rdata_o", rdata_o, expect_word(base + 32'(4 * (i - 1))));
            end
        end
        report_test("back_to_back", e0);
    endtask

    initial begin
        rst     = 1'b0;
        valid_i = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        wstrb_i = '0;
        wdata_i = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        #1 rst = 1'b1;
        test_miss_then_hit(TAG_W'($urandom));
        test_strobes(TAG_W'($urandom));
        test_lru(TAG_W'($urandom));
        test_write_back(TAG_W'($urandom));
        test_back_to_back(TAG_W'($urandom));
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_top.f
hw/dcache_pkg.sv
hw/dcache_array.sv
hw/dcache_req_stage.sv
hw/dcache_lookup.sv
hw/dcache_mem_port.sv
hw/dcache_top.sv
dv/dcache_assert.sv
dv/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)
